// ==== hw/bus_pkg.sv ====
package bus_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	localparam int NUM_MASTERS = 3;
	localparam int NUM_SLAVES = 4;

	// Top address nibble picks the slave
	localparam int SLAVE_SEL_MSB = 31;
	localparam int SLAVE_SEL_LSB = 28;

	// Slave index per address nibble, nibbles 4 to F are unmapped
	localparam int SLAVE_RAM0 = 0;
	localparam int SLAVE_TIMER = 1;
	localparam int SLAVE_MBOX = 2;
	localparam int SLAVE_RAM1 = 3;

	// Wait cycles before a RAM answers
	localparam int RAM_WAIT = 2;

	// Who holds a slave until it answers
	typedef enum logic [1:0] {
		OWNER_NONE = 2'd0,
		OWNER_M0 = 2'd1,
		OWNER_M1 = 2'd2,
		OWNER_M2 = 2'd3
	} lock_owner_t;

endpackage

// ==== hw/periph_pkg.sv ====
package periph_pkg;

	// Timer word offsets, address bits 3 to 2
	typedef enum logic [1:0] {
		TIMER_COUNT = 2'd0,
		TIMER_COMPARE = 2'd1,
		TIMER_CONTROL = 2'd2,
		TIMER_STATUS = 2'd3
	} timer_reg_t;

	localparam int TIMER_ENABLE_BIT = 0;
	localparam int TIMER_MATCH_BIT = 0;

	// Mailbox word offsets, address bit 2
	typedef enum logic [0:0] {
		MBOX_DATA = 1'b0,
		MBOX_STATUS = 1'b1
	} mbox_reg_t;

	localparam int MBOX_DEPTH = 4;
	localparam int MBOX_COUNT_WIDTH = 3;

	// Status word layout
	localparam int MBOX_EMPTY_BIT = 4;
	localparam int MBOX_FULL_BIT = 5;
	localparam int MBOX_OVERFLOW_BIT = 8;

	// RAM sizes in words
	localparam int RAM0_WORDS = 256;
	localparam int RAM1_WORDS = 64;

endpackage

// ==== hw/bus_crossbar.sv ====
`timescale 1ns/1ps

module bus_crossbar import bus_pkg::*; (
	input logic i_clock,
	input logic i_arst_n,

	// Master side
	input logic [NUM_MASTERS-1:0] i_m_request,
	input logic [NUM_MASTERS-1:0] i_m_rw,
	input logic [ADDR_WIDTH-1:0] i_m_address [NUM_MASTERS],
	input logic [DATA_WIDTH-1:0] i_m_wdata [NUM_MASTERS],
	output logic [NUM_MASTERS-1:0] o_m_ready,
	output logic [DATA_WIDTH-1:0] o_m_rdata [NUM_MASTERS],

	// Slave side
	output logic [NUM_SLAVES-1:0] o_s_request,
	output logic [NUM_SLAVES-1:0] o_s_rw,
	output logic [ADDR_WIDTH-1:0] o_s_address [NUM_SLAVES],
	output logic [DATA_WIDTH-1:0] o_s_wdata [NUM_SLAVES],
	input logic [NUM_SLAVES-1:0] i_s_ready,
	input logic [DATA_WIDTH-1:0] i_s_rdata [NUM_SLAVES]
);

	localparam int SEL_WIDTH = SLAVE_SEL_MSB - SLAVE_SEL_LSB + 1;
	localparam int MIDX_WIDTH = $clog2(NUM_MASTERS);

	lock_owner_t lock [NUM_SLAVES];
	lock_owner_t next_lock [NUM_SLAVES];

	// Bit m set when master m requests slave s
	logic [NUM_MASTERS-1:0] slave_hit [NUM_SLAVES];

	logic [NUM_SLAVES-1:0] grant_valid;
	logic [MIDX_WIDTH-1:0] grant_idx [NUM_SLAVES];

	always_comb begin
		for (int s = 0; s < NUM_SLAVES; s++) begin
			for (int m = 0; m < NUM_MASTERS; m++) begin
				slave_hit[s][m] = i_m_request[m] &&
					(i_m_address[m][SLAVE_SEL_MSB:SLAVE_SEL_LSB] == SEL_WIDTH'(s));
			end
		end
	end

	// Lock owner first, otherwise lowest numbered requester
	always_comb begin
		for (int s = 0; s < NUM_SLAVES; s++) begin
			grant_valid[s] = 1'b0;
			grant_idx[s] = '0;
			if (lock[s] != OWNER_NONE) begin
				grant_idx[s] = MIDX_WIDTH'(lock[s] - 1);
				grant_valid[s] = slave_hit[s][grant_idx[s]];
			end else begin
				for (int m = NUM_MASTERS - 1; m >= 0; m--) begin
					if (slave_hit[s][m]) begin
						grant_valid[s] = 1'b1;
						grant_idx[s] = MIDX_WIDTH'(m);
					end
				end
			end
		end
	end

	always_comb begin
		for (int m = 0; m < NUM_MASTERS; m++) begin
			o_m_ready[m] = 1'b0;
			o_m_rdata[m] = '0;
		end

		for (int s = 0; s < NUM_SLAVES; s++) begin
			o_s_request[s] = 1'b0;
			o_s_rw[s] = 1'b0;
			o_s_address[s] = '0;
			o_s_wdata[s] = '0;
			next_lock[s] = OWNER_NONE;

			if (grant_valid[s]) begin
				o_s_request[s] = 1'b1;
				o_s_rw[s] = i_m_rw[grant_idx[s]];
				o_s_address[s] = i_m_address[grant_idx[s]];
				o_s_wdata[s] = i_m_wdata[grant_idx[s]];

				o_m_ready[grant_idx[s]] = i_s_ready[s];
				o_m_rdata[grant_idx[s]] = i_s_rdata[s];

				// Hold until the slave answers
				if (!i_s_ready[s]) begin
					next_lock[s] = lock_owner_t'(grant_idx[s] + 1'b1);
				end
			end
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int s = 0; s < NUM_SLAVES; s++) begin
				lock[s] <= OWNER_NONE;
			end
		end else begin
			for (int s = 0; s < NUM_SLAVES; s++) begin
				lock[s] <= next_lock[s];
			end
		end
	end

endmodule

// ==== hw/wait_ram.sv ====
`timescale 1ns/1ps

module wait_ram import bus_pkg::*; #(
	parameter int WORDS = 256
) (
	input logic i_clock,
	input logic i_arst_n,
	input logic i_request,
	input logic i_rw,
	input logic [ADDR_WIDTH-1:0] i_address,
	input logic [DATA_WIDTH-1:0] i_wdata,
	output logic o_ready,
	output logic [DATA_WIDTH-1:0] o_rdata
);

	localparam int INDEX_WIDTH = $clog2(WORDS);
	localparam int WAIT_WIDTH = $clog2(RAM_WAIT + 1);

	logic [DATA_WIDTH-1:0] mem [WORDS];

	logic [WAIT_WIDTH-1:0] wait_count;
	logic [INDEX_WIDTH-1:0] index;
	logic access;

	// Word index, upper address bits alias
	assign index = i_address[INDEX_WIDTH+1:2];

	// Last wait cycle, ready shows up on the next one
	assign access = i_request && !o_ready && (wait_count == WAIT_WIDTH'(RAM_WAIT - 1));

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wait_count <= '0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= access;
			if (!i_request || o_ready || access) begin
				wait_count <= '0;
			end else begin
				wait_count <= wait_count + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			if (i_rw) begin
				mem[index] <= i_wdata;
			end else begin
				o_rdata <= mem[index];
			end
		end
	end

endmodule

// ==== hw/timer_regs.sv ====
`timescale 1ns/1ps

module timer_regs import bus_pkg::*, periph_pkg::*; (
	input logic i_clock,
	input logic i_arst_n,
	input logic i_request,
	input logic i_rw,
	input logic [ADDR_WIDTH-1:0] i_address,
	input logic [DATA_WIDTH-1:0] i_wdata,
	output logic o_ready,
	output logic [DATA_WIDTH-1:0] o_rdata,
	output logic o_irq
);

	timer_reg_t reg_sel;

	logic [DATA_WIDTH-1:0] count;
	logic [DATA_WIDTH-1:0] compare;
	logic enable;
	logic match;
	logic access;
	logic write;
	logic [DATA_WIDTH-1:0] read_word;

	assign reg_sel = timer_reg_t'(i_address[3:2]);

	// One cycle of latency per access
	assign access = i_request && !o_ready;
	assign write = access && i_rw;

	assign o_irq = match;

	always_comb begin
		read_word = '0;
		case (reg_sel)
			TIMER_COUNT: read_word = count;
			TIMER_COMPARE: read_word = compare;
			TIMER_CONTROL: read_word[TIMER_ENABLE_BIT] = enable;
			TIMER_STATUS: read_word[TIMER_MATCH_BIT] = match;
			default: read_word = '0;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ready <= 1'b0;
			count <= '0;
			compare <= '0;
			enable <= 1'b0;
			match <= 1'b0;
		end else begin
			o_ready <= access;

			if (enable) begin
				count <= count + 1'b1;
			end

			if (write && reg_sel == TIMER_COMPARE) begin
				compare <= i_wdata;
			end
			if (write && reg_sel == TIMER_CONTROL) begin
				enable <= i_wdata[TIMER_ENABLE_BIT];
			end

			// A new match wins over a clear in the same cycle
			if (enable && count == compare) begin
				match <= 1'b1;
			end else if (write && reg_sel == TIMER_STATUS && i_wdata[TIMER_MATCH_BIT]) begin
				match <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (access && !i_rw) begin
			o_rdata <= read_word;
		end
	end

endmodule

// ==== hw/mailbox_fifo.sv ====
`timescale 1ns/1ps

module mailbox_fifo import bus_pkg::*, periph_pkg::*; (
	input logic i_clock,
	input logic i_arst_n,
	input logic i_request,
	input logic i_rw,
	input logic [ADDR_WIDTH-1:0] i_address,
	input logic [DATA_WIDTH-1:0] i_wdata,
	output logic o_ready,
	output logic [DATA_WIDTH-1:0] o_rdata
);

	localparam int PTR_WIDTH = $clog2(MBOX_DEPTH);

	mbox_reg_t reg_sel;

	logic [DATA_WIDTH-1:0] entries [MBOX_DEPTH];

	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [MBOX_COUNT_WIDTH-1:0] count;
	logic overflow;
	logic empty;
	logic full;
	logic access;
	logic push;
	logic pop;
	logic [DATA_WIDTH-1:0] status_word;

	assign reg_sel = mbox_reg_t'(i_address[2]);

	assign access = i_request && !o_ready;
	assign push = access && i_rw && reg_sel == MBOX_DATA;
	assign pop = access && !i_rw && reg_sel == MBOX_DATA;

	assign empty = count == '0;
	assign full = count == MBOX_COUNT_WIDTH'(MBOX_DEPTH);

	always_comb begin
		status_word = '0;
		status_word[MBOX_COUNT_WIDTH-1:0] = count;
		status_word[MBOX_EMPTY_BIT] = empty;
		status_word[MBOX_FULL_BIT] = full;
		status_word[MBOX_OVERFLOW_BIT] = overflow;
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ready <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			o_ready <= access;

			if (push && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
				count <= count + 1'b1;
			end else if (pop && !empty) begin
				rd_ptr <= rd_ptr + 1'b1;
				count <= count - 1'b1;
			end

			// Sticky until software writes status
			if (push && full) begin
				overflow <= 1'b1;
			end else if (access && i_rw && reg_sel == MBOX_STATUS) begin
				overflow <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (push && !full) begin
			entries[wr_ptr] <= i_wdata;
		end

		if (access && !i_rw) begin
			if (reg_sel == MBOX_STATUS) begin
				o_rdata <= status_word;
			end else if (empty) begin
				o_rdata <= '0;
			end else begin
				o_rdata <= entries[rd_ptr];
			end
		end
	end

endmodule

// ==== hw/bus_system.sv ====
`timescale 1ns/1ps

module bus_system import bus_pkg::*, periph_pkg::*; (
	input logic i_clock,
	input logic i_arst_n,

	input logic [NUM_MASTERS-1:0] i_m_request,
	input logic [NUM_MASTERS-1:0] i_m_rw,
	input logic [ADDR_WIDTH-1:0] i_m_address [NUM_MASTERS],
	input logic [DATA_WIDTH-1:0] i_m_wdata [NUM_MASTERS],
	output logic [NUM_MASTERS-1:0] o_m_ready,
	output logic [DATA_WIDTH-1:0] o_m_rdata [NUM_MASTERS],

	output logic o_timer_irq
);

	logic [NUM_SLAVES-1:0] s_request;
	logic [NUM_SLAVES-1:0] s_rw;
	logic [ADDR_WIDTH-1:0] s_address [NUM_SLAVES];
	logic [DATA_WIDTH-1:0] s_wdata [NUM_SLAVES];
	logic [NUM_SLAVES-1:0] s_ready;
	logic [DATA_WIDTH-1:0] s_rdata [NUM_SLAVES];

	bus_crossbar crossbar_inst (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_m_request(i_m_request),
		.i_m_rw(i_m_rw),
		.i_m_address(i_m_address),
		.i_m_wdata(i_m_wdata),
		.o_m_ready(o_m_ready),
		.o_m_rdata(o_m_rdata),
		.o_s_request(s_request),
		.o_s_rw(s_rw),
		.o_s_address(s_address),
		.o_s_wdata(s_wdata),
		.i_s_ready(s_ready),
		.i_s_rdata(s_rdata)
	);

	// Nibble 0
	wait_ram #(
		.WORDS(RAM0_WORDS)
	) ram0 (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(s_request[SLAVE_RAM0]),
		.i_rw(s_rw[SLAVE_RAM0]),
		.i_address(s_address[SLAVE_RAM0]),
		.i_wdata(s_wdata[SLAVE_RAM0]),
		.o_ready(s_ready[SLAVE_RAM0]),
		.o_rdata(s_rdata[SLAVE_RAM0])
	);

	timer_regs timer_inst (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(s_request[SLAVE_TIMER]),
		.i_rw(s_rw[SLAVE_TIMER]),
		.i_address(s_address[SLAVE_TIMER]),
		.i_wdata(s_wdata[SLAVE_TIMER]),
		.o_ready(s_ready[SLAVE_TIMER]),
		.o_rdata(s_rdata[SLAVE_TIMER]),
		.o_irq(o_timer_irq)
	);

	mailbox_fifo mailbox_inst (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(s_request[SLAVE_MBOX]),
		.i_rw(s_rw[SLAVE_MBOX]),
		.i_address(s_address[SLAVE_MBOX]),
		.i_wdata(s_wdata[SLAVE_MBOX]),
		.o_ready(s_ready[SLAVE_MBOX]),
		.o_rdata(s_rdata[SLAVE_MBOX])
	);

	// Nibble 3, smaller copy of ram0
	wait_ram #(
		.WORDS(RAM1_WORDS)
	) ram1 (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(s_request[SLAVE_RAM1]),
		.i_rw(s_rw[SLAVE_RAM1]),
		.i_address(s_address[SLAVE_RAM1]),
		.i_wdata(s_wdata[SLAVE_RAM1]),
		.o_ready(s_ready[SLAVE_RAM1]),
		.o_rdata(s_rdata[SLAVE_RAM1])
	);

endmodule

// ==== sim/bus_system_tb.sv ====
`timescale 1ns/1ps

module bus_system_tb import bus_pkg::*, periph_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 4000;

	// Cycles from raising request to seeing ready
	localparam int RAM_LATENCY = 3;
	localparam int REG_LATENCY = 2;

	localparam logic [ADDR_WIDTH-1:0] TIMER_COUNT_ADDR = 32'h1000_0000;
	localparam logic [ADDR_WIDTH-1:0] TIMER_COMPARE_ADDR = 32'h1000_0004;
	localparam logic [ADDR_WIDTH-1:0] TIMER_CONTROL_ADDR = 32'h1000_0008;
	localparam logic [ADDR_WIDTH-1:0] TIMER_STATUS_ADDR = 32'h1000_000C;
	localparam logic [ADDR_WIDTH-1:0] MBOX_DATA_ADDR = 32'h2000_0000;
	localparam logic [ADDR_WIDTH-1:0] MBOX_STATUS_ADDR = 32'h2000_0004;

	logic clock = 1'b0;
	logic arst_n = 1'b0;
	logic [NUM_MASTERS-1:0] m_request;
	logic [NUM_MASTERS-1:0] m_rw;
	logic [ADDR_WIDTH-1:0] m_address [NUM_MASTERS];
	logic [DATA_WIDTH-1:0] m_wdata [NUM_MASTERS];
	logic [NUM_MASTERS-1:0] m_ready;
	logic [DATA_WIDTH-1:0] m_rdata [NUM_MASTERS];
	logic timer_irq;

	logic [31:0] lfsr_state = 32'hb6bb;
	int cycle_count = 0;

	// Expected RAM contents
	logic [DATA_WIDTH-1:0] ram0_shadow [RAM0_WORDS];
	logic [DATA_WIDTH-1:0] ram1_shadow [RAM1_WORDS];

	bus_system bus_system_inst (
		.i_clock(clock),
		.i_arst_n(arst_n),
		.i_m_request(m_request),
		.i_m_rw(m_rw),
		.i_m_address(m_address),
		.i_m_wdata(m_wdata),
		.o_m_ready(m_ready),
		.o_m_rdata(m_rdata),
		.o_timer_irq(timer_irq)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			report_failure("Timeout: the tests did not finish within the cycle limit");
		end
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Stopping at the first failure");
	endtask

	task automatic check_data(input string test, input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
		if (actual !== expected) begin
			report_failure($sformatf("ERROR %s: expected %h, actual %h", test, expected, actual));
		end
	endtask

	task automatic check_bit(input string test, input logic expected, input logic actual);
		if (actual !== expected) begin
			report_failure($sformatf("ERROR %s: expected %b, actual %b", test, expected, actual));
		end
	endtask

	task automatic check_latency(input string test, input int expected, input int actual);
		if (actual != expected) begin
			report_failure($sformatf("ERROR %s: expected ready after %0d cycles, actual %0d",
				test, expected, actual));
		end
	endtask

	// Right-shift Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	function automatic logic [31:0] random_bits(input int nbits);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] ram0_address(input logic [7:0] index);
		return {4'h0, 18'h0, index, 2'b00};
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] ram1_address(input logic [6:0] index);
		return {4'h3, 19'h0, index, 2'b00};
	endfunction

	function automatic logic [DATA_WIDTH-1:0] mbox_status(input int count, input logic empty,
		input logic full, input logic overflow);
		logic [DATA_WIDTH-1:0] word;
		word = '0;
		word[2:0] = 3'(count);
		word[4] = empty;
		word[5] = full;
		word[8] = overflow;
		return word;
	endfunction

	// One transfer, returns read data and cycles until ready
	task automatic bus_access(input logic [1:0] m, input logic rw,
		input logic [ADDR_WIDTH-1:0] address, input logic [DATA_WIDTH-1:0] wdata,
		output logic [DATA_WIDTH-1:0] rdata, output int latency);
		@(posedge clock);
		m_request[m] <= 1'b1;
		m_rw[m] <= rw;
		m_address[m] <= address;
		m_wdata[m] <= wdata;
		latency = 0;
		do begin
			@(posedge clock);
			latency++;
		end while (!m_ready[m]);
		rdata = m_rdata[m];
		m_request[m] <= 1'b0;
	endtask

	task automatic write_word(input logic [1:0] m, input logic [ADDR_WIDTH-1:0] address,
		input logic [DATA_WIDTH-1:0] data);
		logic [DATA_WIDTH-1:0] unused_rdata;
		int latency;
		bus_access(m, 1'b1, address, data, unused_rdata, latency);
	endtask

	task automatic read_word(input logic [1:0] m, input logic [ADDR_WIDTH-1:0] address,
		output logic [DATA_WIDTH-1:0] data);
		int latency;
		bus_access(m, 1'b0, address, '0, data, latency);
	endtask

	task automatic test_ram();
		logic [7:0] idx0 [4];
		logic [5:0] idx1 [4];
		logic [DATA_WIDTH-1:0] data;
		logic [DATA_WIDTH-1:0] result;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			for (int i = 0; i < 4; i++) begin
				idx0[i] = 8'(random_bits(8));
				idx1[i] = 6'(random_bits(6));
				data = random_bits(32);
				ram0_shadow[idx0[i]] = data;
				write_word(2'(m), ram0_address(idx0[i]), data);
				data = random_bits(32);
				ram1_shadow[idx1[i]] = data;
				write_word(2'(m), ram1_address({1'b0, idx1[i]}), data);
			end
			for (int i = 0; i < 4; i++) begin
				read_word(2'(m), ram0_address(idx0[i]), result);
				check_data("ram", ram0_shadow[idx0[i]], result);
				read_word(2'(m), ram1_address({1'b0, idx1[i]}), result);
				check_data("ram", ram1_shadow[idx1[i]], result);
			end
		end
		// 70 wraps to 6 in the 64 word RAM
		data = random_bits(32);
		write_word(0, ram1_address(7'd70), data);
		ram1_shadow[6] = data;
		read_word(1, ram1_address(7'd6), result);
		check_data("ram alias", ram1_shadow[6], result);
	endtask

	task automatic test_priority();
		logic [7:0] idx;
		logic [DATA_WIDTH-1:0] data0;
		logic [DATA_WIDTH-1:0] data2;
		logic [DATA_WIDTH-1:0] rd0;
		logic [DATA_WIDTH-1:0] rd2;
		logic [DATA_WIDTH-1:0] result;
		int lat0;
		int lat2;
		idx = 8'(random_bits(8));
		data0 = random_bits(32);
		data2 = random_bits(32);
		fork
			bus_access(0, 1'b1, ram0_address(idx), data0, rd0, lat0);
			bus_access(2, 1'b1, ram0_address(idx), data2, rd2, lat2);
		join
		check_latency("priority", RAM_LATENCY, lat0);
		if (lat2 <= lat0) begin
			report_failure("Test priority: master 2 got ready no later than master 0");
		end
		ram0_shadow[idx] = data2;
		read_word(0, ram0_address(idx), result);
		check_data("priority", data2, result);
	endtask

	task automatic test_parallel();
		logic [7:0] idx;
		logic [DATA_WIDTH-1:0] ram_data;
		logic [DATA_WIDTH-1:0] compare_data;
		logic [DATA_WIDTH-1:0] rd0;
		logic [DATA_WIDTH-1:0] rd1;
		int lat0;
		int lat1;
		idx = 8'(random_bits(8));
		ram_data = random_bits(32);
		compare_data = random_bits(32);
		fork
			bus_access(0, 1'b1, ram0_address(idx), ram_data, rd0, lat0);
			bus_access(1, 1'b1, TIMER_COMPARE_ADDR, compare_data, rd1, lat1);
		join
		ram0_shadow[idx] = ram_data;
		check_latency("parallel", RAM_LATENCY, lat0);
		check_latency("parallel", REG_LATENCY, lat1);
		fork
			bus_access(0, 1'b0, ram0_address(idx), '0, rd0, lat0);
			bus_access(1, 1'b0, TIMER_COMPARE_ADDR, '0, rd1, lat1);
		join
		check_data("parallel", ram0_shadow[idx], rd0);
		check_data("parallel", compare_data, rd1);
		check_latency("parallel", RAM_LATENCY, lat0);
		check_latency("parallel", REG_LATENCY, lat1);
	endtask

	task automatic test_timer();
		logic [DATA_WIDTH-1:0] count_a;
		logic [DATA_WIDTH-1:0] count_b;
		logic [DATA_WIDTH-1:0] status;
		write_word(0, TIMER_COMPARE_ADDR, 32'd20);
		write_word(0, TIMER_CONTROL_ADDR, 32'd1);
		read_word(0, TIMER_COUNT_ADDR, count_a);
		read_word(0, TIMER_COUNT_ADDR, count_b);
		check_bit("timer count", 1'b1, count_b > count_a);
		// Poll until the count has passed the compare value
		do begin
			read_word(0, TIMER_COUNT_ADDR, count_b);
		end while (count_b <= 32'd20);
		read_word(0, TIMER_STATUS_ADDR, status);
		check_bit("timer match", 1'b1, status[0]);
		check_bit("timer irq", 1'b1, timer_irq);
		write_word(0, TIMER_STATUS_ADDR, 32'd1);
		read_word(0, TIMER_STATUS_ADDR, status);
		check_bit("timer clear", 1'b0, status[0]);
		check_bit("timer irq clear", 1'b0, timer_irq);
	endtask

	task automatic test_mailbox();
		logic [DATA_WIDTH-1:0] pushed [5];
		logic [DATA_WIDTH-1:0] result;
		for (int i = 0; i < 5; i++) begin
			pushed[i] = random_bits(32);
			write_word(0, MBOX_DATA_ADDR, pushed[i]);
		end
		read_word(0, MBOX_STATUS_ADDR, result);
		check_data("mailbox full", mbox_status(4, 1'b0, 1'b1, 1'b1), result);
		for (int i = 0; i < 4; i++) begin
			read_word(1, MBOX_DATA_ADDR, result);
			check_data("mailbox pop", pushed[i], result);
		end
		read_word(1, MBOX_DATA_ADDR, result);
		check_data("mailbox empty pop", '0, result);
		read_word(1, MBOX_STATUS_ADDR, result);
		check_data("mailbox empty", mbox_status(0, 1'b1, 1'b0, 1'b1), result);
		write_word(1, MBOX_STATUS_ADDR, '0);
		read_word(1, MBOX_STATUS_ADDR, result);
		check_data("mailbox clear", mbox_status(0, 1'b1, 1'b0, 1'b0), result);
	endtask

	initial begin
		m_request = '0;
		m_rw = '0;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			m_address[m] = '0;
			m_wdata[m] = '0;
		end
		repeat (8) @(posedge clock);
		arst_n <= 1'b1;

		test_ram();
		test_priority();
		test_parallel();
		test_timer();
		test_mailbox();

		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== files.f ====
hw/bus_pkg.sv
hw/periph_pkg.sv
hw/bus_crossbar.sv
hw/wait_ram.sv
hw/timer_regs.sv
hw/mailbox_fifo.sv
hw/bus_system.sv
sim/bus_system_tb.sv

// ==== Makefile ====
TOP := bus_system_tb
BIN := obj_dir/V$(TOP)

.PHONY: run clean

run: $(BIN)
	./$(BIN)

$(BIN): files.f $(wildcard hw/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir
